//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes kept by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // ------------------------------
    // Stage payloads
    // ------------------------------
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_e  alu_op;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
        reg_idx_t rd;
        logic     rd_wen;
        logic     is_branch;
        logic     is_bne;
        logic     is_jal;
        logic     is_halt;
        word_t    cmp_b;     // rs2 for branch compares
    } exec_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rd_wen;
        word_t    value;
        logic     halt;
    } retire_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::redirect_t redirect,
    input  logic              halt_req,
    output rv_pkg::word_t     imem_addr,
    output logic              imem_req,
    input  rv_pkg::word_t     inst,
    output rv_pkg::fetch_t    fetch
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_HALT    // Held until reset
    } fetch_state_e;

    fetch_state_e state;
    word_t        pc;
    word_t        req_pc;     // Address of the word now returning
    logic         req_valid;

    assign imem_req  = (state == FETCH_RUN);
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= FETCH_IDLE;
            pc        <= RESET_PC;
            req_valid <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: state <= FETCH_RUN;
                FETCH_RUN:  state <= halt_req ? FETCH_HALT : FETCH_RUN;
                default:    state <= FETCH_HALT;
            endcase
            req_valid <= imem_req && !redirect.valid;  // Drop the fetch behind a redirect
            if (redirect.valid)
                pc <= redirect.target;
            else if (imem_req)
                pc <= pc + word_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        req_pc <= pc;
    end

    assign fetch.valid = req_valid;
    assign fetch.pc    = req_pc;
    assign fetch.inst  = inst;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_value,
    output rv_pkg::word_t    rs2_value,
    input  logic             wen,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    rd_value
);
    import rv_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wen && rd != '0) begin
            regs[rd] <= rd_value;
        end
    end

    // Write-through so the value retiring this cycle is seen by decode
    assign rs1_value = (rs1 == '0)              ? '0       :
                       (wen && rd == rs1)       ? rd_value : regs[rs1];
    assign rs2_value = (rs2 == '0)              ? '0       :
                       (wen && rd == rs2)       ? rd_value : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::fetch_t    fetch,
    input  rv_pkg::redirect_t redirect,
    output rv_pkg::reg_idx_t  rs1,
    output rv_pkg::reg_idx_t  rs2,
    input  rv_pkg::word_t     rs1_value,
    input  rv_pkg::word_t     rs2_value,
    input  rv_pkg::retire_t   ex_bypass,
    input  rv_pkg::retire_t   wb_bypass,
    output rv_pkg::exec_t     exec
);
    import rv_pkg::*;

    localparam word_t    EBREAK_INST = 32'h0010_0073;
    localparam reg_idx_t REG_A0      = 5'd10;

    fetch_t     dec_q;
    exec_t      exec_d;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_ebreak;
    logic       legal;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      rs1_fwd;
    word_t      rs2_fwd;

    // Execute result first, then the entry heading to writeback, then the register file
    function automatic word_t bypass(reg_idx_t idx, word_t rf_val, retire_t ex_src,
                                     retire_t wb_src);
        word_t val;
        val = rf_val;
        if (idx != '0) begin
            if (ex_src.valid && ex_src.rd_wen && ex_src.rd == idx)
                val = ex_src.value;
            else if (wb_src.valid && wb_src.rd_wen && wb_src.rd == idx)
                val = wb_src.value;
        end
        return val;
    endfunction

    // ------------------------------
    // Decode register
    // ------------------------------
    always_ff @(posedge clk) begin
        dec_q <= fetch;
        if (!rst_n || redirect.valid)
            dec_q.valid <= 1'b0;
    end

    assign opcode    = opcode_e'(dec_q.inst[6:0]);
    assign funct3    = dec_q.inst[14:12];
    assign funct7    = dec_q.inst[31:25];
    assign is_ebreak = (dec_q.inst == EBREAK_INST);

    assign imm_i = {{20{dec_q.inst[31]}}, dec_q.inst[31:20]};
    assign imm_u = {dec_q.inst[31:12], 12'b0};
    assign imm_b = {{20{dec_q.inst[31]}}, dec_q.inst[7], dec_q.inst[30:25],
                    dec_q.inst[11:8], 1'b0};
    assign imm_j = {{12{dec_q.inst[31]}}, dec_q.inst[19:12], dec_q.inst[20],
                    dec_q.inst[30:21], 1'b0};

    assign rs1 = is_ebreak ? REG_A0 : dec_q.inst[19:15];  // a0 rides op_a to retire
    assign rs2 = dec_q.inst[24:20];

    assign rs1_fwd = bypass(rs1, rs1_value, ex_bypass, wb_bypass);
    assign rs2_fwd = bypass(rs2, rs2_value, ex_bypass, wb_bypass);

    always_comb begin
        exec_d        = '0;
        exec_d.pc     = dec_q.pc;
        exec_d.rd     = dec_q.inst[11:7];
        exec_d.op_a   = rs1_fwd;
        exec_d.op_b   = rs2_fwd;
        exec_d.cmp_b  = rs2_fwd;
        exec_d.alu_op = ALU_ADD;
        legal         = 1'b1;
        case (opcode)
            OP: begin
                exec_d.rd_wen = 1'b1;
                case (funct3)
                    3'b000:  exec_d.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111:  exec_d.alu_op = ALU_AND;
                    3'b110:  exec_d.alu_op = ALU_OR;
                    3'b100:  exec_d.alu_op = ALU_XOR;
                    3'b010:  exec_d.alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
                if (funct7 != 7'b0 && !(funct3 == 3'b000 && funct7 == 7'b0100000))
                    legal = 1'b0;
            end
            OP_IMM: begin
                exec_d.rd_wen = 1'b1;
                exec_d.op_b   = imm_i;
                exec_d.imm    = imm_i;
                legal         = (funct3 == 3'b000);  // ADDI only
            end
            LUI: begin
                exec_d.rd_wen = 1'b1;
                exec_d.alu_op = ALU_PASS_B;
                exec_d.op_b   = imm_u;
                exec_d.imm    = imm_u;
            end
            BRANCH: begin
                exec_d.is_branch = 1'b1;
                exec_d.is_bne    = funct3[0];
                exec_d.imm       = imm_b;
                legal            = (funct3[2:1] == 2'b00);
            end
            JAL: begin
                exec_d.rd_wen = 1'b1;
                exec_d.is_jal = 1'b1;
                exec_d.imm    = imm_j;
            end
            SYSTEM: begin
                exec_d.is_halt = 1'b1;
                exec_d.op_b    = '0;
                legal          = is_ebreak;
            end
            default: legal = 1'b0;   // Unknown encoding turns into a bubble
        endcase
        exec_d.valid = dec_q.valid && legal;
    end

    // ------------------------------
    // Execute register
    // ------------------------------
    always_ff @(posedge clk) begin
        exec <= exec_d;
        if (!rst_n || redirect.valid)
            exec.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::exec_t     exec,
    output rv_pkg::retire_t   result,
    output rv_pkg::retire_t   ex_bypass,
    output rv_pkg::redirect_t redirect,
    output logic              halt_req
);
    import rv_pkg::*;

    word_t alu_out;
    word_t link_pc;
    logic  equal;
    logic  taken;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (exec.alu_op)
            ALU_ADD:    alu_out = exec.op_a + exec.op_b;
            ALU_SUB:    alu_out = exec.op_a - exec.op_b;
            ALU_AND:    alu_out = exec.op_a & exec.op_b;
            ALU_OR:     alu_out = exec.op_a | exec.op_b;
            ALU_XOR:    alu_out = exec.op_a ^ exec.op_b;
            ALU_SLT:    alu_out = word_t'($signed(exec.op_a) < $signed(exec.op_b));
            ALU_PASS_B: alu_out = exec.op_b;
            default:    alu_out = '0;
        endcase
    end

    assign link_pc = exec.pc + word_t'(4);

    // Branch and jump resolution
    assign equal = (exec.op_a == exec.cmp_b);
    assign taken = exec.is_branch && (equal ^ exec.is_bne);

    assign redirect.valid  = exec.valid && (taken || exec.is_jal || exec.is_halt);
    assign redirect.target = exec.is_halt ? exec.pc : exec.pc + exec.imm;  // EBREAK parks on itself
    assign halt_req        = exec.valid && exec.is_halt;

    assign ex_bypass.valid  = exec.valid;
    assign ex_bypass.pc     = exec.pc;
    assign ex_bypass.rd     = exec.rd;
    assign ex_bypass.rd_wen = exec.rd_wen;
    assign ex_bypass.value  = exec.is_jal ? link_pc : alu_out;
    assign ex_bypass.halt   = exec.is_halt;

    // ------------------------------
    // Result register toward writeback
    // ------------------------------
    always_ff @(posedge clk) begin
        result <= ex_bypass;
        if (!rst_n) begin
            result.valid <= 1'b0;
            result.halt  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::retire_t  result,
    output rv_pkg::retire_t  retire,
    output logic             rf_wen,
    output rv_pkg::reg_idx_t rf_rd,
    output rv_pkg::word_t    rf_value
);
    import rv_pkg::*;

    always_ff @(posedge clk) begin
        retire <= result;
        if (!rst_n) begin
            retire.valid <= 1'b0;
            retire.halt  <= 1'b0;
        end
    end

    // Register file write from the retiring entry
    assign rf_wen   = retire.valid && retire.rd_wen;
    assign rf_rd    = retire.rd;
    assign rf_value = retire.value;

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    output rv_pkg::word_t   imem_addr,
    output logic            imem_req,
    input  rv_pkg::word_t   inst,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    fetch_t    fetch;
    exec_t     exec;
    redirect_t redirect;
    logic      halt_req;
    retire_t   ex_bypass;
    retire_t   wb_entry;      // Result register, entering writeback
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     rs1_value;
    word_t     rs2_value;
    logic      rf_wen;
    reg_idx_t  rf_rd;
    word_t     rf_value;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .halt_req  (halt_req),
        .imem_addr (imem_addr),
        .imem_req  (imem_req),
        .inst      (inst),
        .fetch     (fetch)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wen       (rf_wen),
        .rd        (rf_rd),
        .rd_value  (rf_value)
    );

    decode_stage decode_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch     (fetch),
        .redirect  (redirect),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .ex_bypass (ex_bypass),
        .wb_bypass (wb_entry),
        .exec      (exec)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .exec      (exec),
        .result    (wb_entry),
        .ex_bypass (ex_bypass),
        .redirect  (redirect),
        .halt_req  (halt_req)
    );

    writeback_stage writeback_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .result    (wb_entry),
        .retire    (retire),
        .rf_wen    (rf_wen),
        .rf_rd     (rf_rd),
        .rf_value  (rf_value)
    );

endmodule

`default_nettype wire

//--- sim/rv_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::exec_t     exec,
    input  rv_pkg::redirect_t redirect,
    input  logic              halt_req,
    input  rv_pkg::retire_t   result
);

    logic halted;   // Set by the trap, cleared only by reset

    always_ff @(posedge clk) begin
        if (!rst_n)
            halted <= 1'b0;
        else if (halt_req)
            halted <= 1'b1;
    end

    // Both younger instructions are dropped, so execute sees a bubble next
    redirect_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid |=> !exec.valid)
        else $error("Execute held a valid entry right after a redirect");

    // Fetch stays frozen after the trap
    halt_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !exec.valid)
        else $error("Execute received an entry after the trap");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !result.valid)
        else $error("Valid result produced while in reset");

endmodule

bind execute_stage rv_core_sva sva_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .exec     (exec),
    .redirect (redirect),
    .halt_req (halt_req),
    .result   (result)
);

`default_nettype wire

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam word_t RESET_PC = 32'h0;
    localparam word_t EBREAK   = 32'h0010_0073;

    logic    clk;
    logic    rst_n;
    word_t   imem_addr;
    logic    imem_req;
    word_t   inst;
    retire_t retire;

    word_t   prog_mem [256];
    word_t   prog_q [$];
    retire_t exp_q [$];
    retire_t exp_entry;
    string   test_name;
    int      halt_count;
    int      cycle;
    int      deadline;
    logic    watch_on;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) rv_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_req  (imem_req),
        .inst      (inst),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction memory, one cycle read
    initial begin
        inst = '0;
        forever begin
            @(posedge clk);
            if (imem_req)
                inst <= prog_mem[imem_addr[9:2]];
        end
    end

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic word_t r_inst(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t addi_inst(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t lui_inst(int rd, int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t branch_inst(int bne, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, bne[0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic word_t jal_inst(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // ------------------------------
    // ISA reference model
    // ------------------------------
    function automatic int iss_run();
        word_t   regs [32];
        word_t   pc;
        word_t   ins;
        word_t   a;
        word_t   b;
        word_t   next_pc;
        retire_t e;
        int      count;
        count = 0;
        pc    = RESET_PC;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        repeat (1000) begin
            ins     = prog_mem[pc[9:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            next_pc = pc + 32'd4;
            e       = '0;
            e.valid = 1'b1;
            e.pc    = pc;
            e.rd    = ins[11:7];
            if (ins == EBREAK) begin
                e.halt  = 1'b1;
                e.value = regs[10];     // a0 is the trap code
                exp_q.push_back(e);
                return count + 1;
            end
            case (ins[6:0])
                7'b0110011: begin
                    e.rd_wen = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: e.value = a + b;
                        10'b0100000_000: e.value = a - b;
                        10'b0000000_111: e.value = a & b;
                        10'b0000000_110: e.value = a | b;
                        10'b0000000_100: e.value = a ^ b;
                        10'b0000000_010: e.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         return -1;
                    endcase
                end
                7'b0010011: begin
                    if (ins[14:12] != 3'b000)
                        return -1;
                    e.rd_wen = 1'b1;
                    e.value  = a + {{20{ins[31]}}, ins[31:20]};
                end
                7'b0110111: begin
                    e.rd_wen = 1'b1;
                    e.value  = {ins[31:12], 12'b0};
                end
                7'b1100011: begin
                    if (ins[14:13] != 2'b00)
                        return -1;
                    if (ins[12] ? (a != b) : (a == b))
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'b1101111: begin
                    e.rd_wen = 1'b1;
                    e.value  = pc + 32'd4;
                    next_pc  = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: return -1;
            endcase
            if (e.rd_wen && e.rd != 5'd0)
                regs[e.rd] = e.value;   // x0 stays zero
            exp_q.push_back(e);
            count++;
            pc = next_pc;
        end
        return -1;
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_word(input string field, input word_t exp, input word_t act);
        if (exp !== act)
            fail_run($sformatf("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                               test_name, field, exp, act));
    endtask

    task automatic check_retire(input retire_t exp, input retire_t act);
        compare_word("pc", exp.pc, act.pc);
        compare_word("halt", word_t'(exp.halt), word_t'(act.halt));
        compare_word("rd_wen", word_t'(exp.rd_wen), word_t'(act.rd_wen));
        if (exp.rd_wen) begin
            compare_word("rd", word_t'(exp.rd), word_t'(act.rd));
            compare_word("value", exp.value, act.value);
        end
    endtask

    task automatic check_halt(input retire_t exp, input retire_t act);
        compare_word("trap pc", exp.pc, act.pc);
        compare_word("trap halt", word_t'(exp.halt), word_t'(act.halt));
        compare_word("trap rd_wen", word_t'(exp.rd_wen), word_t'(act.rd_wen));
        compare_word("trap a0", exp.value, act.value);
    endtask

    initial begin
        halt_count = 0;
        forever begin
            @(posedge clk);
            if (rst_n && retire.valid) begin
                if (exp_q.size() == 0) begin
                    fail_run($sformatf("Unexpected retire at pc 0x%08h in %s",
                                       retire.pc, test_name));
                end else begin
                    exp_entry = exp_q.pop_front();
                    if (exp_entry.halt) begin
                        check_halt(exp_entry, retire);
                        halt_count <= halt_count + 1;
                    end else begin
                        check_retire(exp_entry, retire);
                    end
                end
            end
        end
    end

    // Watchdog, budget set per test
    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle <= cycle + 1;
            if (watch_on && cycle > deadline)
                fail_run($sformatf("Timeout in %s: the core never reached its trap", test_name));
        end
    end

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic run_program(input string name);
        int n;
        int halts_before;
        @(posedge clk);
        rst_n     <= 1'b0;
        test_name = name;
        for (int i = 0; i < 256; i++)
            prog_mem[i] = {i[24:0], 7'b0000000};   // Opcode zero, decodes as a bubble
        foreach (prog_q[k])
            prog_mem[int'(RESET_PC[9:2]) + k] = prog_q[k];
        exp_q.delete();
        n = iss_run();
        if (n <= 0)
            fail_run($sformatf("Reference model could not run the %s program", name));
        halts_before = halt_count;
        deadline     <= cycle + 16 + 12 * n;
        watch_on     <= 1'b1;
        repeat (16) begin
            @(posedge clk);
            if (imem_req !== 1'b0 || retire.valid !== 1'b0)
                fail_run($sformatf("%s: fetch or retire active during reset", name));
        end
        rst_n <= 1'b1;
        while (halt_count == halts_before)
            @(posedge clk);
        watch_on <= 1'b0;
        repeat (20) begin                       // Fetch frozen and nothing retires after the trap
            @(posedge clk);
            if (imem_req !== 1'b0)
                fail_run($sformatf("%s: fetch still requesting after the trap", name));
        end
        $display("%s: %0d retires matched", name, n);
    endtask

    task automatic chain_test();
        prog_q.delete();
        prog_q.push_back(addi_inst(1, 0, 5));
        prog_q.push_back(addi_inst(2, 1, 7));          // Execute bypass
        prog_q.push_back(r_inst(7'h00, 3'b000, 3, 1, 2)); // x1 from the result register
        prog_q.push_back(r_inst(7'h20, 3'b000, 4, 3, 1)); // x1 through the register file
        prog_q.push_back(r_inst(7'h00, 3'b000, 5, 4, 2));
        prog_q.push_back(r_inst(7'h20, 3'b000, 6, 0, 5));
        prog_q.push_back(addi_inst(7, 6, -3));
        prog_q.push_back(r_inst(7'h20, 3'b000, 10, 4, 4));
        prog_q.push_back(EBREAK);
        run_program("dependent_chain");
    endtask

    task automatic random_mix_test();
        int rd;
        int rs1;
        int rs2;
        prog_q.delete();
        for (int r = 1; r < 8; r++)
            prog_q.push_back(addi_inst(r, 0, $urandom_range(0, 4095)));
        repeat (40) begin
            rd  = $urandom_range(0, 7);    // x0 included on purpose
            rs1 = $urandom_range(0, 7);
            rs2 = $urandom_range(0, 7);
            case ($urandom_range(0, 7))
                0:       prog_q.push_back(r_inst(7'h00, 3'b000, rd, rs1, rs2));
                1:       prog_q.push_back(r_inst(7'h20, 3'b000, rd, rs1, rs2));
                2:       prog_q.push_back(r_inst(7'h00, 3'b111, rd, rs1, rs2));
                3:       prog_q.push_back(r_inst(7'h00, 3'b110, rd, rs1, rs2));
                4:       prog_q.push_back(r_inst(7'h00, 3'b100, rd, rs1, rs2));
                5:       prog_q.push_back(r_inst(7'h00, 3'b010, rd, rs1, rs2));
                6:       prog_q.push_back(addi_inst(rd, rs1, $urandom_range(0, 4095)));
                default: prog_q.push_back(lui_inst(rd, $urandom));
            endcase
        end
        prog_q.push_back(addi_inst(10, 0, 0));
        prog_q.push_back(EBREAK);
        run_program("random_mix");
    endtask

    task automatic branch_test();
        prog_q.delete();
        prog_q.push_back(addi_inst(1, 0, 3));
        prog_q.push_back(addi_inst(2, 0, 3));
        prog_q.push_back(branch_inst(0, 1, 2, 12));   // BEQ taken
        prog_q.push_back(addi_inst(3, 0, 1));
        prog_q.push_back(addi_inst(4, 0, 1));
        prog_q.push_back(branch_inst(1, 1, 2, 12));   // BNE not taken
        prog_q.push_back(addi_inst(5, 0, 9));
        prog_q.push_back(branch_inst(1, 5, 1, 12));   // BNE taken
        prog_q.push_back(addi_inst(6, 0, 1));
        prog_q.push_back(addi_inst(6, 0, 2));
        prog_q.push_back(branch_inst(0, 5, 1, 8));    // BEQ not taken
        prog_q.push_back(addi_inst(8, 0, 3));
        prog_q.push_back(addi_inst(8, 8, -1));        // Loop body
        prog_q.push_back(branch_inst(1, 8, 0, -4));
        prog_q.push_back(r_inst(7'h00, 3'b000, 7, 5, 8));
        prog_q.push_back(addi_inst(10, 0, 0));
        prog_q.push_back(EBREAK);
        run_program("branches");
    endtask

    task automatic jal_test();
        prog_q.delete();
        prog_q.push_back(addi_inst(2, 0, 1));
        prog_q.push_back(jal_inst(1, 12));
        prog_q.push_back(addi_inst(2, 0, 5));
        prog_q.push_back(addi_inst(3, 0, 5));
        prog_q.push_back(addi_inst(4, 1, 0));         // Reads the link value
        prog_q.push_back(jal_inst(0, 12));
        prog_q.push_back(addi_inst(5, 0, 1));
        prog_q.push_back(addi_inst(5, 0, 2));
        prog_q.push_back(r_inst(7'h00, 3'b000, 6, 4, 2));
        prog_q.push_back(addi_inst(10, 0, 0));
        prog_q.push_back(EBREAK);
        run_program("jal_link");
    endtask

    task automatic bad_trap_test();
        prog_q.delete();
        prog_q.push_back(addi_inst(9, 0, 3));
        prog_q.push_back(addi_inst(10, 9, 4));        // a0 bypassed straight into the trap
        prog_q.push_back(EBREAK);
        prog_q.push_back(addi_inst(11, 0, 1));
        prog_q.push_back(addi_inst(12, 0, 1));
        prog_q.push_back(addi_inst(10, 0, 0));
        run_program("bad_trap");
    endtask

    initial begin
        rst_n    = 1'b0;
        watch_on = 1'b0;
        deadline = 0;
        void'($urandom(81473));
        chain_test();
        random_mix_test();
        branch_test();
        jal_test();
        bad_trap_test();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core.f
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_core.sv
sim/rv_core_sva.sv
sim/rv_core_tb.sv

//--- Makefile
TOP := rv_core_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

obj_dir/V$(TOP): rv_core.f verilog/*.sv sim/*.sv
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f rv_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
